// ==== design/vreg_pkg.sv ====
`default_nettype none

package vreg_pkg;

    localparam int WORD_W    = 32;
    localparam int NUM_LANES = 4;
    localparam int NUM_VREGS = 8;

    // one element, one lane
    typedef logic [WORD_W-1:0] word_t;

    // a whole register, lane 0 in the low word
    typedef logic [NUM_LANES*WORD_W-1:0] vreg_t;

    typedef logic [$clog2(NUM_VREGS)-1:0] vreg_idx_t;

    typedef logic [NUM_LANES-1:0] lane_mask_t;

    // bank write, each lane picks its own word out of data
    typedef struct packed {
        logic       en;
        vreg_idx_t  idx;
        lane_mask_t lane_wen;
        vreg_t      data;
    } vreg_wr_t;

endpackage

`default_nettype wire

// ==== design/vex_pkg.sv ====
`default_nettype none

package vex_pkg;

    // most micro-ops in a register group
    localparam int MAX_UOPS = 4;
    localparam int MAX_VL   = vreg_pkg::NUM_LANES * MAX_UOPS;

    // group size codes, 3 is never issued
    localparam logic [1:0] LMUL_1 = 2'd0;
    localparam logic [1:0] LMUL_2 = 2'd1;
    localparam logic [1:0] LMUL_4 = 2'd2;

    typedef enum logic [3:0] {
        ADD, SUB, AND, OR, XOR, MINU, MAXU, MIN, MAX
    } valu_op_t;

    typedef enum logic {
        ELEM, RED
    } vex_kind_t;

    typedef logic [1:0] lmul_t;
    typedef logic [$clog2(MAX_UOPS)-1:0] uop_num_t;
    typedef logic [$clog2(MAX_VL+1)-1:0] vl_t;

    typedef struct packed {
        vex_kind_t           kind;
        valu_op_t            op;
        lmul_t               lmul;
        vreg_pkg::vreg_idx_t vd;
        vreg_pkg::vreg_idx_t vs1;
        vreg_pkg::vreg_idx_t vs2;
        logic                mask_en;
        vl_t                 vl;
    } vex_cmd_t;

    typedef enum logic [1:0] {
        IDLE, RUN, RED_WB
    } vex_state_t;

endpackage

`default_nettype wire

// ==== design/vec_bank.sv ====
`default_nettype none

module vec_bank #(
    parameter int LANE = 0
) (
    input  logic                CLK,
    input  logic                arst_n,
    input  vreg_pkg::vreg_idx_t rs1_idx,
    input  vreg_pkg::vreg_idx_t rs2_idx,
    input  vreg_pkg::vreg_idx_t rd_idx,
    input  vreg_pkg::vreg_wr_t  wr,
    output vreg_pkg::word_t     rs1_data,
    output vreg_pkg::word_t     rs2_data,
    output vreg_pkg::word_t     rd_data,
    output vreg_pkg::word_t     v0_word
);

    // this lane's word of every register
    vreg_pkg::word_t mem [vreg_pkg::NUM_VREGS];

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            for (int r = 0; r < vreg_pkg::NUM_VREGS; r++) begin
                mem[r] <= '0;
            end
        end else if (wr.en && wr.lane_wen[LANE]) begin
            mem[wr.idx] <= wr.data[LANE*vreg_pkg::WORD_W +: vreg_pkg::WORD_W];
        end
    end

    assign rs1_data = mem[rs1_idx];
    assign rs2_data = mem[rs2_idx];
    assign rd_data  = mem[rd_idx];

    // mask bits live in v0
    assign v0_word  = mem[0];

endmodule

`default_nettype wire

// ==== design/vmask_unit.sv ====
`default_nettype none

module vmask_unit (
    input  vreg_pkg::vreg_t      v0,
    input  logic                 mask_en,
    input  vex_pkg::vl_t         vl,
    input  vex_pkg::uop_num_t    uop_num,
    output vreg_pkg::lane_mask_t lane_mask
);

    vex_pkg::vl_t elem_idx [vreg_pkg::NUM_LANES];

    always_comb begin
        for (int l = 0; l < vreg_pkg::NUM_LANES; l++) begin
            // element number of this lane in the current micro-op
            elem_idx[l] = vex_pkg::vl_t'(int'(uop_num) * vreg_pkg::NUM_LANES + l);

            // tail elements are never written
            lane_mask[l] = (elem_idx[l] < vl);

            if (mask_en && !v0[elem_idx[l]]) begin
                lane_mask[l] = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/vlane_alu.sv ====
`default_nettype none

module vlane_alu (
    input  vex_pkg::valu_op_t op,
    input  vreg_pkg::word_t   a,
    input  vreg_pkg::word_t   b,
    output vreg_pkg::word_t   res
);

    // a carries the vs2 element, b the vs1 element
    logic lt_u;
    logic lt_s;

    assign lt_u = (a < b);
    assign lt_s = ($signed(a) < $signed(b));

    always_comb begin
        case (op)
            vex_pkg::ADD: res = a + b;
            vex_pkg::SUB: res = a - b;
            vex_pkg::AND: res = a & b;
            vex_pkg::OR:  res = a | b;
            vex_pkg::XOR: res = a ^ b;
            vex_pkg::MINU: begin
                res = lt_u ? a : b;
            end
            vex_pkg::MAXU: begin
                res = lt_u ? b : a;
            end
            vex_pkg::MIN: begin
                res = lt_s ? a : b;
            end
            vex_pkg::MAX: begin
                res = lt_s ? b : a;
            end
            default: res = a;
        endcase
    end

endmodule

`default_nettype wire

// ==== design/vred_unit.sv ====
`default_nettype none

module vred_unit (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  vex_pkg::valu_op_t    op,
    input  logic                 first,
    input  logic                 step,
    input  vreg_pkg::word_t      seed,
    input  vreg_pkg::vreg_t      lanes,
    input  vreg_pkg::lane_mask_t lane_mask,
    output vreg_pkg::word_t      acc
);

    vreg_pkg::word_t ident;
    vreg_pkg::word_t padded [vreg_pkg::NUM_LANES];
    vreg_pkg::word_t pair_lo;
    vreg_pkg::word_t pair_hi;
    vreg_pkg::word_t tree_res;
    vreg_pkg::word_t acc_next;

    function automatic vreg_pkg::word_t fold(vex_pkg::valu_op_t f_op,
                                             vreg_pkg::word_t a, vreg_pkg::word_t b);
        case (f_op)
            vex_pkg::AND:  fold = a & b;
            vex_pkg::OR:   fold = a | b;
            vex_pkg::XOR:  fold = a ^ b;
            vex_pkg::MINU: fold = (a < b) ? a : b;
            vex_pkg::MAXU: fold = (a < b) ? b : a;
            vex_pkg::MIN:  fold = ($signed(a) < $signed(b)) ? a : b;
            vex_pkg::MAX:  fold = ($signed(a) < $signed(b)) ? b : a;
            default:       fold = a + b;
        endcase
    endfunction

    // identity value so an inactive lane drops out of the fold
    always_comb begin
        case (op)
            vex_pkg::AND, vex_pkg::MINU: ident = '1;
            vex_pkg::MAX: ident = {1'b1, {(vreg_pkg::WORD_W-1){1'b0}}};
            vex_pkg::MIN: ident = {1'b0, {(vreg_pkg::WORD_W-1){1'b1}}};
            default:      ident = '0;
        endcase
    end

    always_comb begin
        for (int l = 0; l < vreg_pkg::NUM_LANES; l++) begin
            padded[l] = lane_mask[l] ? lanes[l*vreg_pkg::WORD_W +: vreg_pkg::WORD_W] : ident;
        end
    end

    // two-level tree over the four lanes
    assign pair_lo  = fold(op, padded[0], padded[1]);
    assign pair_hi  = fold(op, padded[2], padded[3]);
    assign tree_res = fold(op, pair_lo, pair_hi);
    assign acc_next = fold(op, first ? seed : acc, tree_res);

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            acc <= '0;
        end else if (step) begin
            acc <= acc_next;
        end
    end

endmodule

`default_nettype wire

// ==== design/vuop_counter.sv ====
`default_nettype none

module vuop_counter (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              start,
    input  logic              advance,
    input  vex_pkg::lmul_t    lmul,
    output vex_pkg::uop_num_t uop_num,
    output logic              last
);

    vex_pkg::uop_num_t last_num;

    // number of the final micro-op in the group
    always_comb begin
        case (lmul)
            vex_pkg::LMUL_1: last_num = vex_pkg::uop_num_t'(0);
            vex_pkg::LMUL_2: last_num = vex_pkg::uop_num_t'(1);
            vex_pkg::LMUL_4: last_num = vex_pkg::uop_num_t'(3);
            default:         last_num = '0;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            uop_num <= '0;
        end else if (start) begin
            uop_num <= '0;
        end else if (advance) begin
            uop_num <= uop_num + 1'b1;
        end
    end

    assign last = (uop_num == last_num);

endmodule

`default_nettype wire

// ==== design/vex_ctrl.sv ====
`default_nettype none

module vex_ctrl (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              cmd_valid,
    input  vex_pkg::vex_cmd_t cmd,
    input  logic              last,
    output vex_pkg::vex_cmd_t cur_cmd,
    output logic              start,
    output logic              advance,
    output logic              red_step,
    output logic              red_first,
    output logic              elem_wen,
    output logic              red_wen,
    output logic              busy,
    output logic              done
);

    vex_pkg::vex_state_t state;
    vex_pkg::vex_state_t state_next;
    logic                first_q;
    logic                is_red;

    assign is_red = (cur_cmd.kind == vex_pkg::RED);

    always_comb begin
        state_next = state;
        case (state)
            vex_pkg::IDLE: if (start) state_next = vex_pkg::RUN;
            vex_pkg::RUN: begin
                if (last) begin
                    state_next = is_red ? vex_pkg::RED_WB : vex_pkg::IDLE;
                end
            end
            default: state_next = vex_pkg::IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge arst_n) begin
        if (!arst_n) begin
            state   <= vex_pkg::IDLE;
            cur_cmd <= '0;
            first_q <= 1'b0;
        end else begin
            state <= state_next;
            if (start) begin
                cur_cmd <= cmd;
                first_q <= 1'b1;
            end else if (state == vex_pkg::RUN) begin
                first_q <= 1'b0;
            end
        end
    end

    // commands are only taken while idle
    assign start     = cmd_valid && (state == vex_pkg::IDLE);
    assign advance   = (state == vex_pkg::RUN);
    assign red_step  = advance && is_red;
    assign red_first = red_step && first_q;
    assign elem_wen  = advance && !is_red;
    assign red_wen   = (state == vex_pkg::RED_WB);
    assign busy      = (state != vex_pkg::IDLE);
    assign done      = (elem_wen && last) || red_wen;

endmodule

`default_nettype wire

// ==== design/vex_datapath.sv ====
`default_nettype none

module vex_datapath (
    input  logic                CLK,
    input  logic                arst_n,
    input  logic                cmd_valid,
    input  vex_pkg::vex_cmd_t   cmd,
    output logic                busy,
    output logic                done,
    input  vreg_pkg::vreg_wr_t  ext_wr,
    input  vreg_pkg::vreg_idx_t rd_idx,
    output vreg_pkg::vreg_t     rd_data
);

    localparam int W = vreg_pkg::WORD_W;

    vex_pkg::vex_cmd_t    cur_cmd;
    vex_pkg::uop_num_t    uop_num;
    logic                 last;
    logic                 start;
    logic                 advance;
    logic                 red_step;
    logic                 red_first;
    logic                 elem_wen;
    logic                 red_wen;
    vreg_pkg::vreg_idx_t  vs1_idx;
    vreg_pkg::vreg_idx_t  vs2_idx;
    vreg_pkg::vreg_idx_t  vd_idx;
    vreg_pkg::vreg_t      vs1_data;
    vreg_pkg::vreg_t      vs2_data;
    vreg_pkg::vreg_t      v0;
    vreg_pkg::vreg_t      alu_res;
    vreg_pkg::lane_mask_t lane_mask;
    vreg_pkg::word_t      acc;
    vreg_pkg::vreg_wr_t   ctrl_wr;
    vreg_pkg::vreg_wr_t   bank_wr;

    vex_ctrl i_vex_ctrl (
        .CLK, .arst_n, .cmd_valid, .cmd, .last, .cur_cmd, .start, .advance,
        .red_step, .red_first, .elem_wen, .red_wen, .busy, .done
    );

    vuop_counter i_vuop_counter (
        .CLK, .arst_n, .start, .advance, .lmul(cur_cmd.lmul), .uop_num, .last
    );

    // group member u of register r is r+u
    assign vs1_idx = cur_cmd.vs1 + vreg_pkg::vreg_idx_t'(uop_num);
    assign vs2_idx = cur_cmd.vs2 + vreg_pkg::vreg_idx_t'(uop_num);
    assign vd_idx  = cur_cmd.vd + vreg_pkg::vreg_idx_t'(uop_num);

    for (genvar l = 0; l < vreg_pkg::NUM_LANES; l++) begin : g_lane
        vec_bank #(.LANE(l)) i_vec_bank (
            .CLK, .arst_n,
            .rs1_idx(vs1_idx), .rs2_idx(vs2_idx), .rd_idx,
            .wr(bank_wr),
            .rs1_data(vs1_data[l*W +: W]), .rs2_data(vs2_data[l*W +: W]),
            .rd_data(rd_data[l*W +: W]), .v0_word(v0[l*W +: W])
        );

        vlane_alu i_vlane_alu (
            .op(cur_cmd.op), .a(vs2_data[l*W +: W]), .b(vs1_data[l*W +: W]),
            .res(alu_res[l*W +: W])
        );
    end

    vmask_unit i_vmask_unit (
        .v0, .mask_en(cur_cmd.mask_en), .vl(cur_cmd.vl), .uop_num, .lane_mask
    );

    // seed is element 0 of vs1, read during micro-op 0
    vred_unit i_vred_unit (
        .CLK, .arst_n, .op(cur_cmd.op), .first(red_first), .step(red_step),
        .seed(vs1_data[W-1:0]), .lanes(vs2_data), .lane_mask, .acc
    );

    always_comb begin
        ctrl_wr.en = elem_wen || red_wen;
        if (red_wen) begin
            // reduction result goes to element 0 of vd only
            ctrl_wr.idx      = cur_cmd.vd;
            ctrl_wr.lane_wen = vreg_pkg::lane_mask_t'(1);
            ctrl_wr.data     = {alu_res[vreg_pkg::NUM_LANES*W-1:W], acc};
        end else begin
            ctrl_wr.idx      = vd_idx;
            ctrl_wr.lane_wen = lane_mask;
            ctrl_wr.data     = alu_res;
        end
    end

    // external writes only land while idle
    assign bank_wr = busy ? ctrl_wr : ext_wr;

endmodule

`default_nettype wire

// ==== bench/vex_tb.sv ====
`default_nettype none

module sim_watchdog #(
    parameter int LIMIT_CYCLES = 1000
) (
    input  logic clk,
    output logic expired
);
    timeunit 1ns;
    timeprecision 100ps;

    int unsigned count = 0;

    initial expired = 1'b0;

    always @(posedge clk) begin
        count <= count + 1;
        if (count >= LIMIT_CYCLES) begin
            expired <= 1'b1;
        end
    end

endmodule

module vex_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int W          = vreg_pkg::WORD_W;
    localparam int NUM_ELEM   = 24;
    localparam int NUM_MASKED = 24;
    localparam int NUM_RED    = 32;
    localparam int NUM_CMDS   = NUM_ELEM + NUM_MASKED + NUM_RED;
    // ten cycles per command, plus its readback and one refresh write
    localparam int CMD_CYCLES   = 10 + vreg_pkg::NUM_VREGS + 4;
    localparam int LIMIT_CYCLES = NUM_CMDS * CMD_CYCLES + 200;

    logic                clk       = 1'b0;
    logic                arst_n    = 1'b0;
    logic                cmd_valid = 1'b0;
    vex_pkg::vex_cmd_t   cmd       = '0;
    vreg_pkg::vreg_wr_t  ext_wr    = '0;
    vreg_pkg::vreg_idx_t rd_idx    = '0;
    logic                busy;
    logic                done;
    vreg_pkg::vreg_t     rd_data;
    logic                expired;

    int seed   = 86182;
    int errors = 0;
    int checks = 0;

    // expected contents of every register
    vreg_pkg::vreg_t model [vreg_pkg::NUM_VREGS];

    // SUB is never issued as a reduction
    vex_pkg::valu_op_t red_ops [8] = '{vex_pkg::ADD, vex_pkg::AND, vex_pkg::OR, vex_pkg::XOR,
                                       vex_pkg::MINU, vex_pkg::MAXU, vex_pkg::MIN, vex_pkg::MAX};

    always #4 clk = ~clk;

    vex_datapath i_vex_datapath (
        .CLK(clk), .arst_n, .cmd_valid, .cmd, .busy, .done, .ext_wr, .rd_idx, .rd_data
    );

    sim_watchdog #(.LIMIT_CYCLES(LIMIT_CYCLES)) i_sim_watchdog (.clk, .expired);

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic vreg_pkg::vreg_t rand_vreg();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    // b is the vs1 element, a the vs2 element
    function automatic vreg_pkg::word_t apply_op(input vex_pkg::valu_op_t op,
                                                 input vreg_pkg::word_t a,
                                                 input vreg_pkg::word_t b);
        int sa;
        int sb;
        sa = a;
        sb = b;
        case (op)
            vex_pkg::ADD:  return a + b;
            vex_pkg::SUB:  return a - b;
            vex_pkg::AND:  return a & b;
            vex_pkg::OR:   return a | b;
            vex_pkg::XOR:  return a ^ b;
            vex_pkg::MINU: return (b < a) ? b : a;
            vex_pkg::MAXU: return (b > a) ? b : a;
            vex_pkg::MIN:  return (sb < sa) ? b : a;
            vex_pkg::MAX:  return (sb > sa) ? b : a;
            default:       return a;
        endcase
    endfunction

    function automatic logic elem_active(input vex_pkg::vex_cmd_t c, input int e);
        if (e >= int'(c.vl)) begin
            return 1'b0;
        end
        if (c.mask_en) begin
            return model[0][e];
        end
        return 1'b1;
    endfunction

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: expected %h, actual %h (t=%0t)", name, expected, actual, $time);
        end
    endtask

    task automatic ext_write(input vreg_pkg::vreg_idx_t idx, input vreg_pkg::lane_mask_t wen,
                             input vreg_pkg::vreg_t data);
        vreg_pkg::vreg_wr_t wr;
        wr.en       = 1'b1;
        wr.idx      = idx;
        wr.lane_wen = wen;
        wr.data     = data;
        @(posedge clk);
        ext_wr <= wr;
        @(posedge clk);
        ext_wr <= '0;
        for (int l = 0; l < vreg_pkg::NUM_LANES; l++) begin
            if (wen[l]) begin
                model[idx][l*W +: W] = data[l*W +: W];
            end
        end
    endtask

    task automatic read_all(input string name);
        for (int r = 0; r < vreg_pkg::NUM_VREGS; r++) begin
            @(posedge clk);
            rd_idx <= vreg_pkg::vreg_idx_t'(r);
            @(negedge clk);
            check_value($sformatf("%s v%0d", name, r), model[r], rd_data);
        end
    endtask

    task automatic model_exec(input vex_pkg::vex_cmd_t c);
        vreg_pkg::vreg_idx_t r1;
        vreg_pkg::vreg_idx_t r2;
        vreg_pkg::vreg_idx_t rd;
        vreg_pkg::vreg_t     res;
        vreg_pkg::word_t     acc;
        int                  e;
        acc = model[c.vs1][W-1:0];
        // micro-ops in order, each one sees the writes of the one before
        for (int u = 0; u < (1 << c.lmul); u++) begin
            r1  = vreg_pkg::vreg_idx_t'(int'(c.vs1) + u);
            r2  = vreg_pkg::vreg_idx_t'(int'(c.vs2) + u);
            rd  = vreg_pkg::vreg_idx_t'(int'(c.vd) + u);
            res = model[rd];
            for (int l = 0; l < vreg_pkg::NUM_LANES; l++) begin
                e = u * vreg_pkg::NUM_LANES + l;
                if (elem_active(c, e) && c.kind == vex_pkg::RED) begin
                    acc = apply_op(c.op, acc, model[r2][l*W +: W]);
                end else if (elem_active(c, e)) begin
                    res[l*W +: W] = apply_op(c.op, model[r2][l*W +: W], model[r1][l*W +: W]);
                end
            end
            if (c.kind == vex_pkg::ELEM) begin
                model[rd] = res;
            end
        end
        if (c.kind == vex_pkg::RED) begin
            model[c.vd][W-1:0] = acc;
        end
    endtask

    task automatic random_cmd(output vex_pkg::vex_cmd_t c);
        c.kind    = vex_pkg::ELEM;
        c.op      = vex_pkg::valu_op_t'(rand_below(9));
        c.lmul    = vex_pkg::lmul_t'(rand_below(3));
        c.vd      = vreg_pkg::vreg_idx_t'(rand_below(8));
        c.vs1     = vreg_pkg::vreg_idx_t'(rand_below(8));
        c.vs2     = vreg_pkg::vreg_idx_t'(rand_below(8));
        c.mask_en = 1'b0;
        c.vl      = vex_pkg::vl_t'(rand_below(17));
    endtask

    task automatic run_cmd(input string name, input vex_pkg::vex_cmd_t c);
        vex_pkg::vex_cmd_t  stray;
        vreg_pkg::vreg_wr_t stray_wr;
        int                 n;
        int                 cycle;
        n = (c.kind == vex_pkg::RED) ? (1 << c.lmul) + 1 : (1 << c.lmul);
        random_cmd(stray);
        stray_wr.en       = 1'b1;
        stray_wr.idx      = vreg_pkg::vreg_idx_t'(rand_below(8));
        stray_wr.lane_wen = '1;
        stray_wr.data     = rand_vreg();
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd       <= c;
        @(posedge clk);
        // command taken at this edge, so both of these fall in a busy cycle
        cmd       <= stray;
        ext_wr    <= stray_wr;
        cycle = 1;
        @(negedge clk);
        while (!done && cycle < n + 4) begin
            @(posedge clk);
            cmd_valid <= 1'b0;
            ext_wr    <= '0;
            cycle++;
            @(negedge clk);
        end
        if (!done) begin
            errors++;
            $display("%s: done never arrived within %0d cycles of the command", name, cycle);
        end else begin
            check_value({name, " done cycle"}, n, cycle);
            check_value({name, " busy in done cycle"}, 1, busy);
        end
        @(posedge clk);
        cmd_valid <= 1'b0;
        ext_wr    <= '0;
        @(negedge clk);
        check_value({name, " busy after done"}, 0, busy);
        model_exec(c);
    endtask

    initial begin
        vex_pkg::vex_cmd_t c;
        for (int r = 0; r < vreg_pkg::NUM_VREGS; r++) begin
            model[r] = '0;
        end
        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        check_value("reset busy", 0, busy);
        check_value("reset done", 0, done);
        read_all("reset");

        for (int i = 0; i < 16; i++) begin
            ext_write(vreg_pkg::vreg_idx_t'(rand_below(8)),
                      vreg_pkg::lane_mask_t'(rand_below(16)), rand_vreg());
        end
        read_all("ext write");

        for (int i = 0; i < NUM_ELEM; i++) begin
            ext_write(vreg_pkg::vreg_idx_t'(rand_below(8)), '1, rand_vreg());
            random_cmd(c);
            run_cmd("elem", c);
            read_all("elem");
        end

        // fresh v0 before each masked command
        for (int i = 0; i < NUM_MASKED; i++) begin
            ext_write('0, '1, rand_vreg());
            random_cmd(c);
            c.mask_en = 1'b1;
            run_cmd("masked", c);
            read_all("masked");
        end

        for (int i = 0; i < NUM_RED; i++) begin
            ext_write(vreg_pkg::vreg_idx_t'(rand_below(8)), '1, rand_vreg());
            random_cmd(c);
            c.kind    = vex_pkg::RED;
            c.op      = red_ops[i % 8];
            c.mask_en = rand_below(2) != 0;
            if (i % 5 == 0) begin
                c.vl = '0;
            end
            run_cmd("red", c);
            read_all("red");
        end

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        wait (expired === 1'b1);
        $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
design/vreg_pkg.sv
design/vex_pkg.sv
design/vec_bank.sv
design/vmask_unit.sv
design/vlane_alu.sv
design/vred_unit.sv
design/vuop_counter.sv
design/vex_ctrl.sv
design/vex_datapath.sv
bench/vex_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps -Wno-fatal \
    --top-module vex_tb --Mdir obj_dir -o vex_tb_sim -f tb.f

./obj_dir/vex_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -qxF "NO ERRORS" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
